//--- common/rv_pipe_cfg.svh
`ifndef RV_PIPE_CFG_SVH
`define RV_PIPE_CFG_SVH

// data word and address width
`define RV_XLEN 32

// commit-order counter
`define RV_ORDER_W 64

// destination register index
`define RV_REG_ADDR_W 5

// byte lanes per word for the byte enable
`define RV_BYTES 4

`endif

//--- common/rv_pipe_pkg.sv
`include "rv_pipe_cfg.svh"

package rv_pipe_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_e;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_e;

    typedef enum logic [1:0] {
        exe_fwd_alu_out    = 2'b00,
        exe_fwd_br_en_zext = 2'b01,
        exe_fwd_u_imm      = 2'b10
    } exe_fwd_sel_e;

    typedef enum logic {
        mar_pc_out  = 1'b0,
        mar_alu_out = 1'b1
    } mar_sel_e;

    typedef enum logic {
        mem_fwd_mem_rdata    = 1'b0,
        mem_fwd_exe_fwd_data = 1'b1
    } mem_fwd_sel_e;

    typedef struct packed {
        logic          mem_read;
        logic          mem_write;
        load_funct3_e  load_funct3;
        store_funct3_e store_funct3;
        mar_sel_e      mar_sel;
        mem_fwd_sel_e  mem_fwd_sel;
    } mem_ctrl_t;

    typedef struct packed {
        logic                      ld_reg;
        logic [`RV_REG_ADDR_W-1:0] rd_sel;
    } wb_ctrl_t;

    typedef struct packed {
        exe_fwd_sel_e exe_fwd_sel;
        mem_ctrl_t    mem;
        wb_ctrl_t     wb;
    } ctrl_word_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
        word_t pc_wdata;
    } fetch_pkt_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        word_t      pc;
        word_t      u_imm;
    } dec_pkt_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        word_t      exe_fwd_data;
        word_t      u_imm;
        logic       br_en;
    } exe_mem_pkt_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        word_t      mem_fwd_data;
        word_t      mem_rdata;
        word_t      alu_out;
        word_t      u_imm;
        logic       br_en;
    } mem_wb_pkt_t;

endpackage

//--- mem_stage/exe_mem_reg.sv
`include "rv_pipe_cfg.svh"

module exe_mem_reg (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load_i,
    input  rv_pipe_pkg::ctrl_word_t   ctrl_i,
    input  rv_pipe_pkg::word_t        pc_i,
    input  rv_pipe_pkg::word_t        u_imm_i,
    input  rv_pipe_pkg::word_t        alu_out_i,
    input  logic                      br_en_i,
    input  rv_pipe_pkg::word_t        rs2_i,
    output rv_pipe_pkg::exe_mem_pkt_t pkt_o,
    output logic                      valid_o,
    output rv_pipe_pkg::word_t        dmem_addr_o,
    output rv_pipe_pkg::word_t        dmem_wdata_o,
    output logic [`RV_BYTES-1:0]      dmem_be_o
);

    localparam int off_w = $clog2(`RV_BYTES);
    localparam logic [`RV_BYTES-1:0] word_mask = '1;
    localparam logic [`RV_BYTES-1:0] half_mask = 'b11;
    localparam logic [`RV_BYTES-1:0] byte_mask = 'b1;

    rv_pipe_pkg::word_t        fwd_data;
    rv_pipe_pkg::word_t        mar_addr;
    rv_pipe_pkg::word_t        aligned_addr;
    rv_pipe_pkg::word_t        mem_addr;
    logic [off_w-1:0]          offset;
    logic [`RV_BYTES-1:0]      be_d;
    logic                      mem_ld;
    rv_pipe_pkg::exe_mem_pkt_t pkt_d;

    always_comb begin : exe_fwd_mux
        case (ctrl_i.exe_fwd_sel)
            rv_pipe_pkg::exe_fwd_br_en_zext: fwd_data = {{(`RV_XLEN-1){1'b0}}, br_en_i};
            rv_pipe_pkg::exe_fwd_u_imm:      fwd_data = u_imm_i;
            default:                         fwd_data = alu_out_i;
        endcase
    end

    assign mar_addr = (ctrl_i.mem.mar_sel == rv_pipe_pkg::mar_pc_out) ? pc_i : alu_out_i;
    assign offset = mar_addr[off_w-1:0];
    assign aligned_addr = {mar_addr[`RV_XLEN-1:off_w], {off_w{1'b0}}};

    always_comb begin : byte_mask_calc
        be_d = '0;
        mem_addr = mar_addr;
        if (ctrl_i.mem.mem_read) begin // read wins over write
            case (ctrl_i.mem.load_funct3)
                rv_pipe_pkg::lw: be_d = word_mask;
                rv_pipe_pkg::lh, rv_pipe_pkg::lhu: begin
                    be_d = half_mask << offset;
                    mem_addr = aligned_addr;
                end
                rv_pipe_pkg::lb, rv_pipe_pkg::lbu: begin
                    be_d = byte_mask << offset;
                    mem_addr = aligned_addr;
                end
                default: be_d = '0;
            endcase
        end else if (ctrl_i.mem.mem_write) begin
            case (ctrl_i.mem.store_funct3)
                rv_pipe_pkg::sw: be_d = word_mask;
                rv_pipe_pkg::sh: begin
                    be_d = half_mask << offset;
                    mem_addr = aligned_addr;
                end
                rv_pipe_pkg::sb: begin
                    be_d = byte_mask << offset;
                    mem_addr = aligned_addr;
                end
                default: be_d = '0;
            endcase
        end
    end

    assign mem_ld = load_i & (ctrl_i.mem.mem_read | ctrl_i.mem.mem_write);

    // primed here so the memory stage can start on the next cycle
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            dmem_addr_o  <= '0;
            dmem_wdata_o <= '0;
            dmem_be_o    <= '0;
        end else if (mem_ld) begin
            dmem_addr_o  <= mem_addr;
            dmem_wdata_o <= rs2_i;
            dmem_be_o    <= be_d;
        end
    end

    always_comb begin
        pkt_d.ctrl         = ctrl_i;
        pkt_d.exe_fwd_data = fwd_data;
        pkt_d.u_imm        = u_imm_i;
        pkt_d.br_en        = br_en_i;
    end

    stage_reg #(
        .payload_t (rv_pipe_pkg::exe_mem_pkt_t)
    ) i_em_reg (
        .clk     (clk),
        .rst     (rst),
        .load_i  (load_i),
        .pkt_i   (pkt_d),
        .pkt_o   (pkt_o),
        .valid_o (valid_o)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_pipeline_latches \
    -o sim_pipeline_latches > build.log 2>&1 \
    && ./obj_dir/sim_pipeline_latches > sim.log 2>&1 \
    || echo "build or run error, see build.log and sim.log"
grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1

//--- src/fetch_decode_reg.sv
`include "rv_pipe_cfg.svh"

module fetch_decode_reg (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load_i,
    input  rv_pipe_pkg::fetch_pkt_t  pkt_i,
    output rv_pipe_pkg::fetch_pkt_t  pkt_o,
    output logic                     valid_o,
    output logic [`RV_ORDER_W-1:0]   order_o
);

    logic [`RV_ORDER_W-1:0] order_q;

    stage_reg #(
        .payload_t (rv_pipe_pkg::fetch_pkt_t)
    ) i_fd_reg (
        .clk     (clk),
        .rst     (rst),
        .load_i  (load_i),
        .pkt_i   (pkt_i),
        .pkt_o   (pkt_o),
        .valid_o (valid_o)
    );

    // one count per fetched instruction
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            order_q <= '0;
        end else if (load_i) begin
            order_q <= order_q + 1'b1;
        end
    end

    assign order_o = order_q;

endmodule

//--- src/mem_wb_reg.sv
module mem_wb_reg (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      load_i,
    input  rv_pipe_pkg::exe_mem_pkt_t em_pkt_i,
    input  rv_pipe_pkg::word_t        dmem_rdata_i,
    output rv_pipe_pkg::mem_wb_pkt_t  pkt_o,
    output logic                      valid_o
);

    rv_pipe_pkg::word_t       mem_fwd;
    rv_pipe_pkg::mem_wb_pkt_t pkt_d;

    always_comb begin : mem_fwd_mux
        if (em_pkt_i.ctrl.mem.mem_fwd_sel == rv_pipe_pkg::mem_fwd_mem_rdata) begin
            mem_fwd = dmem_rdata_i;
        end else begin
            mem_fwd = em_pkt_i.exe_fwd_data;
        end
    end

    always_comb begin
        pkt_d.ctrl         = em_pkt_i.ctrl;
        pkt_d.mem_fwd_data = mem_fwd;
        pkt_d.mem_rdata    = dmem_rdata_i;
        pkt_d.alu_out      = em_pkt_i.exe_fwd_data; // exe forward data doubles as alu result
        pkt_d.u_imm        = em_pkt_i.u_imm;
        pkt_d.br_en        = em_pkt_i.br_en;
    end

    stage_reg #(
        .payload_t (rv_pipe_pkg::mem_wb_pkt_t)
    ) i_mw_reg (
        .clk     (clk),
        .rst     (rst),
        .load_i  (load_i),
        .pkt_i   (pkt_d),
        .pkt_o   (pkt_o),
        .valid_o (valid_o)
    );

endmodule

//--- src/pipeline_latches.sv
`include "rv_pipe_cfg.svh"

module pipeline_latches (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fd_load_i,
    input  logic                      de_load_i,
    input  logic                      em_load_i,
    input  logic                      mw_load_i,
    input  rv_pipe_pkg::fetch_pkt_t   fetch_pkt_i,
    input  rv_pipe_pkg::dec_pkt_t     dec_pkt_i,
    input  rv_pipe_pkg::word_t        alu_out_i,
    input  logic                      br_en_i,
    input  rv_pipe_pkg::word_t        rs2_i,
    input  rv_pipe_pkg::word_t        dmem_rdata_i,
    output rv_pipe_pkg::fetch_pkt_t   fd_pkt_o,
    output logic                      fd_valid_o,
    output logic [`RV_ORDER_W-1:0]    order_o,
    output rv_pipe_pkg::dec_pkt_t     de_pkt_o,
    output logic                      de_valid_o,
    output rv_pipe_pkg::exe_mem_pkt_t em_pkt_o,
    output logic                      em_valid_o,
    output rv_pipe_pkg::word_t        dmem_addr_o,
    output rv_pipe_pkg::word_t        dmem_wdata_o,
    output logic [`RV_BYTES-1:0]      dmem_be_o,
    output rv_pipe_pkg::mem_wb_pkt_t  mw_pkt_o,
    output logic                      mw_valid_o
);

    rv_pipe_pkg::dec_pkt_t     de_pkt;
    rv_pipe_pkg::exe_mem_pkt_t em_pkt;

    fetch_decode_reg i_fetch_decode (
        .clk (clk), .rst (rst), .load_i (fd_load_i),
        .pkt_i (fetch_pkt_i), .pkt_o (fd_pkt_o),
        .valid_o (fd_valid_o), .order_o (order_o)
    );

    stage_reg #(
        .payload_t (rv_pipe_pkg::dec_pkt_t)
    ) i_decode_exe (
        .clk (clk), .rst (rst), .load_i (de_load_i),
        .pkt_i (dec_pkt_i), .pkt_o (de_pkt), .valid_o (de_valid_o)
    );

    // execute stage results arrive alongside the decoded control word
    exe_mem_reg i_exe_mem (
        .clk (clk), .rst (rst), .load_i (em_load_i),
        .ctrl_i (de_pkt.ctrl), .pc_i (de_pkt.pc), .u_imm_i (de_pkt.u_imm),
        .alu_out_i (alu_out_i), .br_en_i (br_en_i), .rs2_i (rs2_i),
        .pkt_o (em_pkt), .valid_o (em_valid_o),
        .dmem_addr_o (dmem_addr_o), .dmem_wdata_o (dmem_wdata_o),
        .dmem_be_o (dmem_be_o)
    );

    mem_wb_reg i_mem_wb (
        .clk (clk), .rst (rst), .load_i (mw_load_i),
        .em_pkt_i (em_pkt), .dmem_rdata_i (dmem_rdata_i),
        .pkt_o (mw_pkt_o), .valid_o (mw_valid_o)
    );

    assign de_pkt_o = de_pkt;
    assign em_pkt_o = em_pkt;

endmodule

//--- src/stage_reg.sv
module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     load_i,
    input  payload_t pkt_i,
    output payload_t pkt_o,
    output logic     valid_o
);

    payload_t pkt_q;
    logic     valid_q;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pkt_q   <= '0;
            valid_q <= 1'b0;
        end else if (load_i) begin
            pkt_q   <= pkt_i;
            valid_q <= 1'b1; // sticky until reset
        end
    end

    // holds while load is low
    assign pkt_o   = pkt_q;
    assign valid_o = valid_q;

endmodule

//--- verification/pipeline_latches_props.sv
`include "rv_pipe_cfg.svh"

module pipeline_latches_props (
    input logic                  clk,
    input logic                  rst,
    input logic                  em_load_i,
    input rv_pipe_pkg::dec_pkt_t de_pkt_o,
    input logic                  fd_valid_o,
    input logic                  de_valid_o,
    input logic                  em_valid_o,
    input logic                  mw_valid_o,
    input rv_pipe_pkg::word_t    dmem_addr_o,
    input rv_pipe_pkg::word_t    dmem_wdata_o,
    input logic [`RV_BYTES-1:0]  dmem_be_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [3:0] valids;
    logic       mem_ld;
    int         fail_cnt = 0;

    assign valids = {mw_valid_o, em_valid_o, de_valid_o, fd_valid_o};
    assign mem_ld = em_load_i & (de_pkt_o.ctrl.mem.mem_read | de_pkt_o.ctrl.mem.mem_write);

    valid_sticky: assert property (@(posedge clk) disable iff (rst)
        (($past(valids) & ~valids) == 4'b0000))
        else begin
            fail_cnt++;
            $error("a valid flag fell while out of reset");
        end

    be_legal: assert property (@(posedge clk) disable iff (rst)
        dmem_be_o inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                          4'b0011, 4'b0110, 4'b1100, 4'b1111})
        else begin
            fail_cnt++;
            $error("illegal byte enable pattern %h", dmem_be_o);
        end

    dmem_hold: assert property (@(posedge clk) disable iff (rst)
        !mem_ld |=> $stable({dmem_addr_o, dmem_wdata_o, dmem_be_o}))
        else begin
            fail_cnt++;
            $error("data memory port changed without a memory load");
        end

endmodule

bind pipeline_latches pipeline_latches_props i_props (
    .clk (clk), .rst (rst), .em_load_i (em_load_i), .de_pkt_o (de_pkt_o),
    .fd_valid_o (fd_valid_o), .de_valid_o (de_valid_o),
    .em_valid_o (em_valid_o), .mw_valid_o (mw_valid_o),
    .dmem_addr_o (dmem_addr_o), .dmem_wdata_o (dmem_wdata_o), .dmem_be_o (dmem_be_o)
);

//--- verification/tb_pipeline_latches.sv
`include "rv_pipe_cfg.svh"

module tb_pipeline_latches;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int phase_cycles = 400;
    localparam int total_cycles = 3 + 5 + 3 * phase_cycles + 4;
    localparam int timeout_ns = total_cycles * 20 + 2000;

    typedef struct packed {
        rv_pipe_pkg::word_t   fwd;
        rv_pipe_pkg::word_t   addr;
        logic [`RV_BYTES-1:0] be;
        logic                 mem_op;
    } exe_ref_t;

    logic clk;
    logic rst;
    logic [3:0] loads; // mw, em, de, fd
    rv_pipe_pkg::fetch_pkt_t fetch_pkt, fd_pkt, fd_m;
    rv_pipe_pkg::dec_pkt_t dec_pkt, de_pkt, de_m;
    rv_pipe_pkg::exe_mem_pkt_t em_pkt, em_m;
    rv_pipe_pkg::mem_wb_pkt_t mw_pkt, mw_m;
    rv_pipe_pkg::word_t alu_out, rs2, dmem_rdata, dmem_addr, dmem_wdata, addr_m, wdata_m;
    logic br_en, fd_valid, de_valid, em_valid, mw_valid;
    logic [`RV_BYTES-1:0] dmem_be, be_m;
    logic [`RV_ORDER_W-1:0] order, order_m;
    logic [3:0] valid_m;
    int errors = 0;
    int checks = 0;
    int stall_cnt [4];

    pipeline_latches i_dut (
        .clk (clk), .rst (rst),
        .fd_load_i (loads[0]), .de_load_i (loads[1]), .em_load_i (loads[2]), .mw_load_i (loads[3]),
        .fetch_pkt_i (fetch_pkt), .dec_pkt_i (dec_pkt), .alu_out_i (alu_out), .br_en_i (br_en),
        .rs2_i (rs2), .dmem_rdata_i (dmem_rdata),
        .fd_pkt_o (fd_pkt), .fd_valid_o (fd_valid), .order_o (order),
        .de_pkt_o (de_pkt), .de_valid_o (de_valid), .em_pkt_o (em_pkt), .em_valid_o (em_valid),
        .dmem_addr_o (dmem_addr), .dmem_wdata_o (dmem_wdata), .dmem_be_o (dmem_be),
        .mw_pkt_o (mw_pkt), .mw_valid_o (mw_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // forward select, address source and byte mask from the execute stage rules
    function automatic exe_ref_t ref_exe_mem(input rv_pipe_pkg::ctrl_word_t ctrl,
                                             input rv_pipe_pkg::word_t pc,
                                             input rv_pipe_pkg::word_t u_imm,
                                             input rv_pipe_pkg::word_t alu,
                                             input logic br);
        exe_ref_t r;
        rv_pipe_pkg::word_t sel_addr;
        logic [1:0] off;
        int size;
        size = 0;
        case (ctrl.exe_fwd_sel)
            rv_pipe_pkg::exe_fwd_alu_out:    r.fwd = alu;
            rv_pipe_pkg::exe_fwd_br_en_zext: r.fwd = 32'(br);
            default:                         r.fwd = u_imm;
        endcase
        sel_addr = (ctrl.mem.mar_sel == rv_pipe_pkg::mar_pc_out) ? pc : alu;
        off = sel_addr[1:0];
        r.mem_op = ctrl.mem.mem_read | ctrl.mem.mem_write;
        if (ctrl.mem.mem_read) begin
            case (ctrl.mem.load_funct3)
                rv_pipe_pkg::lw:                   size = 4;
                rv_pipe_pkg::lh, rv_pipe_pkg::lhu: size = 2;
                rv_pipe_pkg::lb, rv_pipe_pkg::lbu: size = 1;
                default:                           size = 0;
            endcase
        end else if (ctrl.mem.mem_write) begin
            case (ctrl.mem.store_funct3)
                rv_pipe_pkg::sw: size = 4;
                rv_pipe_pkg::sh: size = 2;
                rv_pipe_pkg::sb: size = 1;
                default:         size = 0;
            endcase
        end
        r.addr = sel_addr;
        r.be = 4'b0000;
        if (size == 4) r.be = 4'b1111;
        if (size == 2) r.be = 4'b0011 << off;
        if (size == 1) r.be = 4'b0001 << off;
        if (size == 2 || size == 1) r.addr = {sel_addr[31:2], 2'b00}; // sub-word goes aligned
        return r;
    endfunction

    task automatic check_field(input string name, input logic [159:0] got,
                               input logic [159:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic drive_payloads();
        rv_pipe_pkg::dec_pkt_t d;
        d.ctrl = rv_pipe_pkg::ctrl_word_t'(18'($urandom));
        d.ctrl.exe_fwd_sel = rv_pipe_pkg::exe_fwd_sel_e'(2'($urandom % 3));
        d.pc = $urandom;
        d.u_imm = $urandom;
        dec_pkt <= d;
        fetch_pkt <= {$urandom, $urandom, $urandom};
        alu_out <= $urandom;
        rs2 <= $urandom;
        dmem_rdata <= $urandom;
        br_en <= 1'($urandom);
    endtask

    task automatic run_phase(input string name, input int cycles, input int load_pct,
                             input int max_stall);
        int err_start;
        logic [3:0] ld;
        err_start = errors;
        for (int c = 0; c < cycles; c++) begin
            @(posedge clk);
            for (int s = 0; s < 4; s++) begin
                if (stall_cnt[s] > 0) begin
                    ld[s] = 1'b0;
                    stall_cnt[s]--;
                end else begin
                    ld[s] = ($urandom % 100) < load_pct;
                    if (max_stall > 0 && ($urandom % 8) == 0) stall_cnt[s] = $urandom % max_stall;
                end
            end
            loads <= ld;
            drive_payloads();
        end
        $display("test %s: %0d cycles, %0d errors", name, cycles, errors - err_start);
    endtask

    // model holds the state expected after the next rising edge
    always @(negedge clk) begin : compare_outputs
        exe_ref_t r;
        if (rst) begin
            fd_m = '0;
            de_m = '0;
            em_m = '0;
            mw_m = '0;
            valid_m = '0;
            order_m = '0;
            addr_m = '0;
            wdata_m = '0;
            be_m = '0;
        end else begin
            check_field("fd_pkt_o", 160'(fd_pkt), 160'(fd_m));
            check_field("order_o", 160'(order), 160'(order_m));
            check_field("valid_o", 160'({mw_valid, em_valid, de_valid, fd_valid}), 160'(valid_m));
            check_field("de_pkt_o", 160'(de_pkt), 160'(de_m));
            check_field("em_pkt_o", 160'(em_pkt), 160'(em_m));
            check_field("dmem_addr_o", 160'(dmem_addr), 160'(addr_m));
            check_field("dmem_wdata_o", 160'(dmem_wdata), 160'(wdata_m));
            check_field("dmem_be_o", 160'(dmem_be), 160'(be_m));
            check_field("mw_pkt_o", 160'(mw_pkt), 160'(mw_m));
            r = ref_exe_mem(de_m.ctrl, de_m.pc, de_m.u_imm, alu_out, br_en);
            if (loads[3]) begin // downstream first so each stage reads the old upstream value
                mw_m.ctrl = em_m.ctrl;
                mw_m.mem_fwd_data = (em_m.ctrl.mem.mem_fwd_sel == rv_pipe_pkg::mem_fwd_mem_rdata)
                                    ? dmem_rdata : em_m.exe_fwd_data;
                mw_m.mem_rdata = dmem_rdata;
                mw_m.alu_out = em_m.exe_fwd_data;
                mw_m.u_imm = em_m.u_imm;
                mw_m.br_en = em_m.br_en;
            end
            if (loads[2]) begin
                em_m = {de_m.ctrl, r.fwd, de_m.u_imm, br_en};
                if (r.mem_op) begin
                    addr_m = r.addr;
                    wdata_m = rs2;
                    be_m = r.be;
                end
            end
            if (loads[1]) de_m = dec_pkt;
            if (loads[0]) begin
                fd_m = fetch_pkt;
                order_m = order_m + 64'd1;
            end
            valid_m = valid_m | loads;
        end
    end

    initial begin
        void'($urandom(46));
        rst = 1'b1;
        loads = '0;
        fetch_pkt = '0;
        dec_pkt = '0;
        alu_out = '0;
        br_en = 1'b0;
        rs2 = '0;
        dmem_rdata = '0;
        foreach (stall_cnt[s]) stall_cnt[s] = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        run_phase("reset_values", 5, 0, 0);
        run_phase("steady_flow", phase_cycles, 90, 0);
        run_phase("long_stalls", phase_cycles, 50, 40);
        run_phase("mixed_traffic", phase_cycles, 70, 10);
        @(posedge clk);
        loads <= '0;
        repeat (2) @(negedge clk);
        $display("checks: %0d, errors: %0d, property failures: %0d",
                 checks, errors, i_dut.i_props.fail_cnt);
        if (errors == 0 && i_dut.i_props.fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("timeout: run did not finish within %0d ns", timeout_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+common
common/rv_pipe_pkg.sv
src/stage_reg.sv
src/fetch_decode_reg.sv
mem_stage/exe_mem_reg.sv
src/mem_wb_reg.sv
src/pipeline_latches.sv
verification/pipeline_latches_props.sv
verification/tb_pipeline_latches.sv
